/* hdl/ramCmdPkg.sv */
`default_nettype none
//--------------------------------------------------
// memory-side command word
// data and address width defaults
//--------------------------------------------------

package ramCmdPkg;

	//--------------------------------------------------
	// width defaults
	//--------------------------------------------------

	// RAM data bus width
	localparam int ramDqWidthDef = 8;

	// kept small so the RAM array simulates quickly
	localparam int ramAdrsWidthDef = 8;

	//--------------------------------------------------
	// command word
	//--------------------------------------------------

	// one FIFO word per command across the clock boundary
	// msb first: write flag, address, data
	typedef struct packed {
		// high for write, low for read
		logic write;
		// word address into the RAM array
		logic [ramAdrsWidthDef-1:0] adrs;
		// write data, a read ignores it
		logic [ramDqWidthDef-1:0] data;
	} ramCmd_t;

endpackage

`default_nettype wire

/* hdl/ufiPkg.sv */
`default_nettype none
//--------------------------------------------------
// system-side request and response words
// requester ID width
//--------------------------------------------------

package ufiPkg;

	import ramCmdPkg::*;

	// requester ID width
	localparam int ufiIdWidth = 3;

	//--------------------------------------------------
	// request and response
	//--------------------------------------------------

	// request from a requester on sysClk
	typedef struct packed {
		// command handed to the memory side
		ramCmd_t cmd;
		// requester ID, only kept for reads
		logic [ufiIdWidth-1:0] id;
	} ufiReq_t;

	// response back to the requester
	typedef struct packed {
		// word read from the RAM
		logic [ramDqWidthDef-1:0] rdData;
		// ID of the read that asked for it
		logic [ufiIdWidth-1:0] id;
	} ufiRsp_t;

endpackage

`default_nettype wire

/* hdl/fifoDualControllerGray.sv */
`timescale 1ns/100ps
`default_nettype none
//--------------------------------------------------
// dual-clock FIFO, Gray-coded pointer crossing
// reset synchronizer per clock domain
// full, empty and registered read-valid
//--------------------------------------------------

module fifoDualControllerGray #(
	// power of two, at least 4
	parameter int pBuffDepth = 16,
	parameter int pBitWidth = 8
) (
	// write side, srcClk domain
	input wire logic [pBitWidth-1:0] wd,
	input wire we,
	output logic full,
	// read side, dstClk domain
	output logic [pBitWidth-1:0] rd,
	input wire re,
	output logic rvd,
	output logic emp,
	// common
	input wire arstN,
	input wire srcClk,
	input wire dstClk
);

	localparam int lpAdrsW = $clog2(pBuffDepth);

	// binary to Gray
	function automatic logic [lpAdrsW:0] binToGray(input logic [lpAdrsW:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	// storage
	logic [pBitWidth-1:0] mem [pBuffDepth];

	// reset release per domain
	logic [1:0] srcRstSync;
	logic [1:0] dstRstSync;
	logic srcRstN;
	logic dstRstN;

	// write pointer and its crossing
	logic [lpAdrsW:0] wrPtrBin;
	logic [lpAdrsW:0] wrPtrNext;
	logic [lpAdrsW:0] wrPtrGray;
	logic [lpAdrsW:0] wrGrayMeta;
	logic [lpAdrsW:0] wrGraySync;
	logic wrEn;

	// read pointer and its crossing
	logic [lpAdrsW:0] rdPtrBin;
	logic [lpAdrsW:0] rdPtrNext;
	logic [lpAdrsW:0] rdPtrGray;
	logic [lpAdrsW:0] rdGrayMeta;
	logic [lpAdrsW:0] rdGraySync;
	logic rdEn;

	//--------------------------------------------------
	// reset synchronizers
	//--------------------------------------------------

	// assert at once, release after two srcClk edges
	always_ff @(posedge srcClk or negedge arstN) begin
		if (!arstN) begin
			srcRstSync <= 2'b00;
		end else begin
			srcRstSync <= {srcRstSync[0], 1'b1};
		end
	end

	// same on the read clock
	always_ff @(posedge dstClk or negedge arstN) begin
		if (!arstN) begin
			dstRstSync <= 2'b00;
		end else begin
			dstRstSync <= {dstRstSync[0], 1'b1};
		end
	end

	assign srcRstN = srcRstSync[1];
	assign dstRstN = dstRstSync[1];

	//--------------------------------------------------
	// write side
	//--------------------------------------------------

	// full when the write pointer has lapped the read pointer
	// in Gray code: top two bits inverted, rest equal
	assign full = (wrPtrGray == {~rdGraySync[lpAdrsW -: 2], rdGraySync[lpAdrsW-2:0]});
	assign wrEn = we && !full;
	assign wrPtrNext = wrPtrBin + 1'b1;

	always_ff @(posedge srcClk or negedge srcRstN) begin
		if (!srcRstN) begin
			wrPtrBin <= '0;
			wrPtrGray <= '0;
			rdGrayMeta <= '0;
			rdGraySync <= '0;
		end else begin
			// read pointer into srcClk, two flops
			rdGrayMeta <= rdPtrGray;
			rdGraySync <= rdGrayMeta;
			if (wrEn) begin
				wrPtrBin <= wrPtrNext;
				wrPtrGray <= binToGray(wrPtrNext);
			end
		end
	end

	always_ff @(posedge srcClk) begin
		if (wrEn) begin
			mem[wrPtrBin[lpAdrsW-1:0]] <= wd;
		end
	end

	//--------------------------------------------------
	// read side
	//--------------------------------------------------

	// empty when both Gray pointers agree
	assign emp = (rdPtrGray == wrGraySync);
	assign rdEn = re && !emp;
	assign rdPtrNext = rdPtrBin + 1'b1;

	always_ff @(posedge dstClk or negedge dstRstN) begin
		if (!dstRstN) begin
			rdPtrBin <= '0;
			rdPtrGray <= '0;
			wrGrayMeta <= '0;
			wrGraySync <= '0;
			rvd <= 1'b0;
		end else begin
			// write pointer into dstClk
			wrGrayMeta <= wrPtrGray;
			wrGraySync <= wrGrayMeta;
			// word valid on rd one cycle after the pop
			rvd <= rdEn;
			if (rdEn) begin
				rdPtrBin <= rdPtrNext;
				rdPtrGray <= binToGray(rdPtrNext);
			end
		end
	end

	always_ff @(posedge dstClk) begin
		if (rdEn) begin
			rd <= mem[rdPtrBin[lpAdrsW-1:0]];
		end
	end

endmodule

`default_nettype wire

/* hdl/fifoController.sv */
`timescale 1ns/100ps
`default_nettype none
//--------------------------------------------------
// single-clock FIFO, circular buffer with count
// registered read-valid
//--------------------------------------------------

module fifoController #(
	// at least 2
	parameter int pFifoDepth = 16,
	parameter int pFifoBitWidth = 8
) (
	input wire logic [pFifoBitWidth-1:0] wd,
	input wire we,
	output logic full,
	output logic [pFifoBitWidth-1:0] rd,
	input wire re,
	output logic rvd,
	output logic emp,
	input wire arstN,
	input wire clk
);

	localparam int lpPtrW = $clog2(pFifoDepth);
	localparam int lpCntW = lpPtrW + 1;

	logic [pFifoBitWidth-1:0] buff [pFifoDepth];
	logic [lpPtrW-1:0] wrPtr;
	logic [lpPtrW-1:0] rdPtr;
	logic [lpCntW-1:0] count;
	logic wrEn;
	logic rdEn;

	// status from the fill count
	assign full = (count == lpCntW'(pFifoDepth));
	assign emp = (count == '0);
	assign wrEn = we && !full;
	assign rdEn = re && !emp;

	//--------------------------------------------------
	// pointers and count
	//--------------------------------------------------
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			rvd <= 1'b0;
		end else begin
			// wrap at depth, need not be a power of two
			if (wrEn) begin
				wrPtr <= (wrPtr == lpPtrW'(pFifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (rdEn) begin
				rdPtr <= (rdPtr == lpPtrW'(pFifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({wrEn, rdEn})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// same read timing as the dual-clock FIFO
			rvd <= rdEn;
		end
	end

	// storage and read register
	always_ff @(posedge clk) begin
		if (wrEn) begin
			buff[wrPtr] <= wd;
		end
		if (rdEn) begin
			rd <= buff[rdPtr];
		end
	end

endmodule

`default_nettype wire

/* hdl/RAMDualClkFifo.sv */
`timescale 1ns/100ps
`default_nettype none
//--------------------------------------------------
// sysClk to memClk bridge for RAM commands
// command FIFO, read-data FIFO, requester ID FIFO
// response pairing stage
//--------------------------------------------------

module RAMDualClkFifo import ramCmdPkg::*, ufiPkg::*; #(
	parameter int pDualClkFifoDepth = 16
) (
	input wire sysClk,
	input wire memClk,
	input wire arstN,
	// requester side, sysClk
	input wire reqValid,
	input wire ufiReq_t reqData,
	output logic reqFull,
	output logic rspValid,
	output ufiRsp_t rspData,
	// memory side, memClk
	output ramCmd_t memCmd,
	output logic memCmdValid,
	input wire memCmdPop,
	input wire logic [ramDqWidthDef-1:0] memRdData,
	input wire memRdPush,
	output logic memRdFull
);

	// outstanding reads can fill both dual-clock FIFOs at once
	localparam int lpIdFifoDepth = 4 * pDualClkFifoDepth;

	logic reqAccept;
	logic cmdFull;
	logic cmdEmp;
	logic idFull;
	logic rdPop;
	logic rdEmp;
	logic rdVd;
	logic [ramDqWidthDef-1:0] rdWord;
	logic idVd;
	logic [ufiIdWidth-1:0] idWord;

	//--------------------------------------------------
	// request split
	//--------------------------------------------------

	// no room for the command or for a read's ID
	assign reqFull = cmdFull || idFull;
	// strobe while full is dropped
	assign reqAccept = reqValid && !reqFull;

	// sysClk -> memClk
	fifoDualControllerGray #(
		.pBuffDepth (pDualClkFifoDepth),
		.pBitWidth  ($bits(ramCmd_t))
	) cmdFifo (
		.wd     (reqData.cmd),
		.we     (reqAccept),
		.full   (cmdFull),
		.rd     (memCmd),
		.re     (memCmdPop),
		.rvd    (),
		.emp    (cmdEmp),
		.arstN  (arstN),
		.srcClk (sysClk),
		.dstClk (memClk)
	);

	// a word is waiting for the executor
	assign memCmdValid = !cmdEmp;

	// ID stays on sysClk, reads only
	fifoController #(
		.pFifoDepth    (lpIdFifoDepth),
		.pFifoBitWidth (ufiIdWidth)
	) idFifo (
		.wd    (reqData.id),
		.we    (reqAccept && !reqData.cmd.write),
		.full  (idFull),
		.rd    (idWord),
		.re    (rdPop),
		.rvd   (idVd),
		.emp   (),
		.arstN (arstN),
		.clk   (sysClk)
	);

	//--------------------------------------------------
	// read data return
	//--------------------------------------------------

	// memClk -> sysClk
	fifoDualControllerGray #(
		.pBuffDepth (pDualClkFifoDepth),
		.pBitWidth  (ramDqWidthDef)
	) rdFifo (
		.wd     (memRdData),
		.we     (memRdPush),
		.full   (memRdFull),
		.rd     (rdWord),
		.re     (rdPop),
		.rvd    (rdVd),
		.emp    (rdEmp),
		.arstN  (arstN),
		.srcClk (memClk),
		.dstClk (sysClk)
	);

	// drain as soon as data arrives, ID popped with it
	assign rdPop = !rdEmp;

	// both read-valids rise together, pack into one strobe
	always_ff @(posedge sysClk or negedge arstN) begin
		if (!arstN) begin
			rspValid <= 1'b0;
		end else begin
			rspValid <= rdVd && idVd;
		end
	end

	always_ff @(posedge sysClk) begin
		if (rdVd) begin
			rspData.rdData <= rdWord;
			rspData.id <= idWord;
		end
	end

endmodule

`default_nettype wire

/* hdl/ramCore.sv */
`timescale 1ns/100ps
`default_nettype none
//--------------------------------------------------
// memClk-side command executor
// RAM array with post-reset clear
//--------------------------------------------------

module ramCore import ramCmdPkg::*; #(
	parameter int pRamWords = 2 ** ramAdrsWidthDef
) (
	input wire memClk,
	input wire arstN,
	// command FIFO read side
	input wire ramCmd_t memCmd,
	input wire memCmdValid,
	output logic memCmdPop,
	// read-data FIFO write side
	output logic [ramDqWidthDef-1:0] memRdData,
	output logic memRdPush,
	input wire memRdFull
);

	localparam int lpClrW = $clog2(pRamWords);

	logic [ramDqWidthDef-1:0] ramArray [pRamWords];

	// clear sequencer state
	logic clearing;
	logic [lpClrW-1:0] clrAdrs;

	// command word present on memCmd
	logic cmdLive;

	//--------------------------------------------------
	// pop control
	//--------------------------------------------------

	// one pop per cycle, held off by clear and full return path
	assign memCmdPop = memCmdValid && !clearing && !memRdFull;

	// walk all words once after reset
	always_ff @(posedge memClk or negedge arstN) begin
		if (!arstN) begin
			clearing <= 1'b1;
			clrAdrs <= '0;
		end else if (clearing) begin
			clrAdrs <= clrAdrs + 1'b1;
			if (clrAdrs == lpClrW'(pRamWords - 1)) begin
				clearing <= 1'b0;
			end
		end
	end

	// popped word shows up on memCmd next cycle
	always_ff @(posedge memClk or negedge arstN) begin
		if (!arstN) begin
			cmdLive <= 1'b0;
			memRdPush <= 1'b0;
		end else begin
			cmdLive <= memCmdPop;
			// push together with the registered array word
			memRdPush <= cmdLive && !memCmd.write;
		end
	end

	//--------------------------------------------------
	// array access
	//--------------------------------------------------
	always_ff @(posedge memClk) begin
		// clear and commands never overlap, pops wait for the clear
		if (clearing) begin
			ramArray[clrAdrs] <= '0;
		end else if (cmdLive && memCmd.write) begin
			ramArray[memCmd.adrs] <= memCmd.data;
		end
		if (cmdLive && !memCmd.write) begin
			memRdData <= ramArray[memCmd.adrs];
		end
	end

endmodule

`default_nettype wire

/* hdl/ramBridgeTop.sv */
`timescale 1ns/100ps
`default_nettype none
//--------------------------------------------------
// top level, clock bridge plus RAM executor
//--------------------------------------------------

module ramBridgeTop import ramCmdPkg::*, ufiPkg::*; #(
	// power of two, at least 4
	parameter int pDualClkFifoDepth = 16,
	parameter int pRamWords = 2 ** ramAdrsWidthDef
) (
	input wire sysClk,
	input wire memClk,
	input wire arstN,
	// request strobe, no back-pressure
	input wire reqValid,
	input wire ufiReq_t reqData,
	// advisory
	output logic reqFull,
	// response strobe, issue order
	output logic rspValid,
	output ufiRsp_t rspData
);

	// memClk side links
	ramCmd_t memCmd;
	logic memCmdValid;
	logic memCmdPop;
	logic [ramDqWidthDef-1:0] memRdData;
	logic memRdPush;
	logic memRdFull;

	RAMDualClkFifo #(
		.pDualClkFifoDepth (pDualClkFifoDepth)
	) bridge (
		.sysClk      (sysClk),
		.memClk      (memClk),
		.arstN       (arstN),
		.reqValid    (reqValid),
		.reqData     (reqData),
		.reqFull     (reqFull),
		.rspValid    (rspValid),
		.rspData     (rspData),
		.memCmd      (memCmd),
		.memCmdValid (memCmdValid),
		.memCmdPop   (memCmdPop),
		.memRdData   (memRdData),
		.memRdPush   (memRdPush),
		.memRdFull   (memRdFull)
	);

	ramCore #(
		.pRamWords (pRamWords)
	) core (
		.memClk      (memClk),
		.arstN       (arstN),
		.memCmd      (memCmd),
		.memCmdValid (memCmdValid),
		.memCmdPop   (memCmdPop),
		.memRdData   (memRdData),
		.memRdPush   (memRdPush),
		.memRdFull   (memRdFull)
	);

endmodule

`default_nettype wire

/* verification/ramBridgeTb.sv */
`timescale 1ns/100ps
`default_nettype none
//--------------------------------------------------
// testbench for the RAM clock bridge
// stimulus table, reference memory, compare tasks
// watchdog
//--------------------------------------------------

module ramBridgeTb import ramCmdPkg::*, ufiPkg::*; ();

	localparam int resetCycles = 10;
	localparam int idleCycles = 200;
	localparam int drainCycles = 100;
	localparam int cyclesPerEntry = 100;
	localparam int refWords = 2 ** ramAdrsWidthDef;

	logic sysClk;
	logic memClk;
	logic arstN;
	logic reqValid;
	ufiReq_t reqData;
	logic reqFull;
	logic rspValid;
	ufiRsp_t rspData;

	// stimulus table with one slot per request
	string tabName [$];
	ufiReq_t tabReq [$];
	int tabGap [$];

	// reference memory and responses still owed
	logic [ramDqWidthDef-1:0] refMem [refWords];
	ufiRsp_t expRsp [$];
	string expName [$];

	int seed = 52;

	ramBridgeTop #(
		.pDualClkFifoDepth (8)
	) DUT (
		.sysClk   (sysClk),
		.memClk   (memClk),
		.arstN    (arstN),
		.reqValid (reqValid),
		.reqData  (reqData),
		.reqFull  (reqFull),
		.rspValid (rspValid),
		.rspData  (rspData)
	);

	//--------------------------------------------------
	// clocks
	//--------------------------------------------------
	initial begin
		sysClk = 1'b0;
		forever #4 sysClk = ~sysClk;
	end

	// unrelated 5 ns memory clock
	initial begin
		memClk = 1'b0;
		forever #2.5 memClk = ~memClk;
	end

	//--------------------------------------------------
	// helpers
	//--------------------------------------------------
	task automatic stopWithFail();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped on first error");
	endtask

	function automatic logic [ramDqWidthDef-1:0] randomByte();
		logic [31:0] r;
		r = $random(seed);
		return r[ramDqWidthDef-1:0];
	endfunction

	task automatic compareFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %b actual %b", name, expected, actual);
			stopWithFail();
		end
	endtask

	// oldest expected response against the one just seen
	task automatic compareRsp(input ufiRsp_t actual);
		ufiRsp_t expected;
		string name;
		if (expRsp.size() == 0) begin
			$display("response strobe with no read outstanding, id %0d", actual.id);
			stopWithFail();
		end else begin
			expected = expRsp.pop_front();
			name = expName.pop_front();
			if (actual !== expected) begin
				$display("ERROR %s expected data %h id %0d, actual data %h id %0d",
					name, expected.rdData, expected.id, actual.rdData, actual.id);
				stopWithFail();
			end
		end
	endtask

	task automatic addEntry(
		input string name,
		input logic write,
		input logic [ramAdrsWidthDef-1:0] adrs,
		input logic [ramDqWidthDef-1:0] data,
		input logic [ufiIdWidth-1:0] id,
		input int gap
	);
		ufiReq_t req;
		req.cmd.write = write;
		req.cmd.adrs = adrs;
		req.cmd.data = data;
		req.id = id;
		tabName.push_back(name);
		tabReq.push_back(req);
		tabGap.push_back(gap);
	endtask

	//--------------------------------------------------
	// stimulus table
	//--------------------------------------------------
	task automatic buildTable();
		// write then read back
		addEntry("write 0x10", 1'b1, 8'h10, 8'hA5, 3'd0, 0);
		addEntry("read back 0x10", 1'b0, 8'h10, 8'h00, 3'd3, 4);
		// cleared after reset
		addEntry("read unwritten 0x80", 1'b0, 8'h80, 8'h00, 3'd5, 4);
		addEntry("read unwritten 0xff", 1'b0, 8'hFF, 8'h00, 3'd6, 4);
		// fill 0x20..0x26 for the burst
		for (int i = 0; i < 7; i++) begin
			addEntry($sformatf("burst fill %0d", i), 1'b1, 8'(32 + i), randomByte(), 3'd0, 0);
		end
		// back-to-back reads with distinct IDs
		for (int i = 0; i < 7; i++) begin
			addEntry($sformatf("burst read %0d", i), 1'b0, 8'(32 + i), 8'h00, 3'(i),
				(i == 6) ? 20 : 0);
		end
		// overlapping addresses where the last write wins
		// each value differs from the one it overwrites
		addEntry("mix write 0x40 a", 1'b1, 8'h40, 8'h5A, 3'd0, 0);
		addEntry("mix read 0x40 a", 1'b0, 8'h40, 8'h00, 3'd1, 0);
		addEntry("mix write 0x40 b", 1'b1, 8'h40, 8'hC3, 3'd0, 0);
		addEntry("mix write 0x41", 1'b1, 8'h41, 8'h96, 3'd0, 0);
		addEntry("mix read 0x40 b", 1'b0, 8'h40, 8'h00, 3'd2, 0);
		addEntry("mix read 0x41", 1'b0, 8'h41, 8'h00, 3'd4, 2);
		addEntry("mix write 0x41 b", 1'b1, 8'h41, 8'h69, 3'd0, 0);
		addEntry("mix read 0x41 b", 1'b0, 8'h41, 8'h00, 3'd7, 10);
	endtask

	// one request strobe with the reference model updated in issue order
	task automatic applyEntry(input int idx);
		ufiReq_t req;
		ufiRsp_t exp;
		req = tabReq[idx];
		// hold the strobe until the advisory full drops
		while (reqFull) begin
			@(negedge sysClk);
		end
		reqData = req;
		reqValid = 1'b1;
		if (req.cmd.write) begin
			refMem[req.cmd.adrs] = req.cmd.data;
		end else begin
			exp.rdData = refMem[req.cmd.adrs];
			exp.id = req.id;
			expRsp.push_back(exp);
			expName.push_back(tabName[idx]);
		end
		@(negedge sysClk);
		reqValid = 1'b0;
		repeat (tabGap[idx]) @(negedge sysClk);
	endtask

	//--------------------------------------------------
	// main sequence
	//--------------------------------------------------
	initial begin
		reqValid = 1'b0;
		reqData = '0;
		arstN = 1'b1;
		for (int a = 0; a < refWords; a++) begin
			refMem[a] = '0;
		end
		buildTable();
		@(negedge sysClk);
		arstN = 1'b0;
		repeat (resetCycles) @(negedge sysClk);
		arstN = 1'b1;
		// quiet outputs for longer than the RAM clear
		repeat (idleCycles) begin
			@(negedge sysClk);
			compareFlag("idle reqFull", 1'b0, reqFull);
			compareFlag("idle rspValid", 1'b0, rspValid);
		end
		for (int i = 0; i < tabReq.size(); i++) begin
			applyEntry(i);
		end
		while (expRsp.size() != 0) begin
			@(negedge sysClk);
		end
		// extra strobes would land here
		repeat (drainCycles) @(negedge sysClk);
		$display("Simulation finished: PASS");
		$finish;
	end

	// sample mid-cycle once the outputs have settled
	always @(negedge sysClk) begin
		if (arstN && rspValid) begin
			compareRsp(rspData);
		end
	end

	//--------------------------------------------------
	// watchdog
	//--------------------------------------------------
	initial begin
		int limit;
		#1;
		limit = tabReq.size() * cyclesPerEntry + resetCycles + idleCycles + drainCycles;
		repeat (limit) @(posedge sysClk);
		$display("watchdog expired after %0d sysClk cycles, %0d responses outstanding",
			limit, expRsp.size());
		stopWithFail();
	end

endmodule

`default_nettype wire

/* sim.f */
hdl/ramCmdPkg.sv
hdl/ufiPkg.sv
hdl/fifoDualControllerGray.sv
hdl/fifoController.sv
hdl/RAMDualClkFifo.sv
hdl/ramCore.sv
hdl/ramBridgeTop.sv
verification/ramBridgeTb.sv

/* Makefile */
# Verilator build and run for the RAM clock bridge

VERILATOR  ?= verilator
TOP        := ramBridgeTb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# exit status of the simulation is the result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
